// File: Makefile
VERILATOR ?= verilator
TOP       := map90_tb
FILE_LIST := list.f
OBJ_DIR   := obj_dir
FLAGS     := --binary --timing --assert -Wno-fatal

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILE_LIST)

# A $fatal in the testbench gives a non-zero exit status
run: compile
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

// File: list.f
+incdir+.
map90_pkg.sv
map90_regs.sv
map90_irq.sv
map90_prg_map.sv
map90_chr_map.sv
map90_top.sv
map90_tb.sv

// File: map90_chr_map.sv
`timescale 1ns/10ps
`include "map90_config.svh"

module map90_chr_map
(
	input  map90_pkg::map_regs_t    regs,
	input  logic [13:0]             ppu_addr,
	output logic [`MAP90_CHR_W-1:0] chr_addr,
	output logic                    ciram_a10,
	output logic                    ciram_ce
);

	map90_pkg::chr_mode_e chr_mode;
	map90_pkg::mirror_e   mirror_mode;
	logic [2:0]           slot;
	logic [8:0]           chr_bank;
	logic [1:0]           nt_idx;
	logic                 nt_rom;
	logic                 nt_ram_off;
	logic                 nt_ram_sel;
	logic                 mir_a10;

	assign chr_mode = map90_pkg::chr_mode_e'(regs.control[0][4:3]);
	assign mirror_mode = map90_pkg::mirror_e'(regs.control[1][1:0]);
	assign nt_rom = regs.control[0][5]; // Nametables through nt_reg
	assign nt_ram_off = regs.control[0][6];
	assign nt_ram_sel = regs.control[2][7];
	assign nt_idx = ppu_addr[11:10];

	// CHR mirror folds 1K slots 2 and 3 back onto 0 and 1
	assign slot = (regs.control[3][7] && ppu_addr[12:11] == 2'b01) ?
		{2'b00, ppu_addr[10]} : ppu_addr[12:10];

	always_comb
	begin
		case (chr_mode)
			map90_pkg::CHR_8K: chr_bank = {regs.chr_reg[0][5:0], ppu_addr[12:10]};
			map90_pkg::CHR_4K:
				chr_bank = {(ppu_addr[12] ? regs.chr_reg[4][6:0] : regs.chr_reg[0][6:0]),
					ppu_addr[11:10]};
			map90_pkg::CHR_2K: chr_bank = {regs.chr_reg[{slot[2:1], 1'b0}][7:0], ppu_addr[10]};
			default: chr_bank = regs.chr_reg[slot][8:0];
		endcase
	end

	always_comb
	begin
		case (mirror_mode)
			map90_pkg::MIR_VERT: mir_a10 = ppu_addr[10];
			map90_pkg::MIR_HORZ: mir_a10 = ppu_addr[11];
			map90_pkg::MIR_ONE_LO: mir_a10 = 1'b0;
			default: mir_a10 = 1'b1;
		endcase
	end

	assign chr_addr[9:0] = ppu_addr[9:0];
	assign chr_addr[`MAP90_CHR_W-1:10] = (ppu_addr[13] && nt_rom) ?
		regs.nt_reg[nt_idx][8:0] : chr_bank;

	assign ciram_a10 = nt_rom ? regs.nt_reg[nt_idx][0] : mir_a10;

	// Active low, a ROM-routed nametable keeps CIRAM off
	assign ciram_ce = !ppu_addr[13] ? 1'b1 :
		!nt_rom ? 1'b0 :
		nt_ram_off ? 1'b1 : (nt_ram_sel != regs.nt_reg[nt_idx][7]);

endmodule

// File: map90_config.svh
`ifndef MAP90_CONFIG_SVH
`define MAP90_CONFIG_SVH

// CPU side bus
`define MAP90_ADR_W 16
`define MAP90_DAT_W 8

// ROM address outputs
`define MAP90_PRG_W 19
`define MAP90_CHR_W 19

// m2 cycles of A12 low before a rise is counted
`define MAP90_A12_FILT 3

`define MAP90_MUL_BASE 16'h5800 // Operands and product at 5800, 5801
`define MAP90_RAM_BASE 16'h5800 // Scratch RAM visible at 5802..5807

`endif

// File: map90_irq.sv
`timescale 1ns/10ps
`include "map90_config.svh"

module map90_irq
(
	input  logic               m2,
	input  logic               map_rst,
	input  map90_pkg::irq_wr_t irq_wr,
	input  logic               ppu_a12,
	output logic               irq
);

	localparam int FILT = `MAP90_A12_FILT;
	localparam int LW = $clog2(FILT + 1);

	logic [`MAP90_DAT_W-1:0] mode;
	logic [`MAP90_DAT_W-1:0] prescale;
	logic [`MAP90_DAT_W-1:0] count;
	logic [`MAP90_DAT_W-1:0] xor_val;
	logic                    irq_on;
	logic                    irq_inc;
	logic [2:0]              a12_sh;
	logic [LW-1:0]           low_cnt;
	logic                    a12_rise;
	logic                    step;
	logic                    wrap;
	logic                    short_pre;
	map90_pkg::irq_src_e     src;
	map90_pkg::irq_dir_e     dir;

	assign src = map90_pkg::irq_src_e'(mode[1:0]);
	assign dir = map90_pkg::irq_dir_e'(mode[7:6]);
	assign short_pre = mode[2]; // 3-bit prescaler

	// Rise only counts after A12 sat low long enough
	assign a12_rise = a12_sh[1] & !a12_sh[2] & (low_cnt == LW'(FILT));
	assign step = (src == map90_pkg::SRC_CPU || (src == map90_pkg::SRC_A12 && a12_rise))
		&& irq_wr.op == map90_pkg::IRQ_NONE;
	assign wrap = short_pre ? (prescale[2:0] == 3'h7) : (prescale == 8'hff);

	always_ff @(posedge m2)
	begin
		if (map_rst)
		begin
			a12_sh <= '0;
			low_cnt <= '0;
		end
		else
		begin
			a12_sh <= {a12_sh[1:0], ppu_a12};
			if (a12_sh[1])
				low_cnt <= '0;
			else if (low_cnt != LW'(FILT))
				low_cnt <= low_cnt + 1'b1; // Saturates at the filter length
		end
	end

	always_ff @(posedge m2)
	begin
		if (map_rst)
		begin
			mode <= '0;
			prescale <= '0;
			count <= '0;
			xor_val <= '0;
			irq_on <= 1'b0;
			irq_inc <= 1'b0;
			irq <= 1'b0;
		end
		else
		begin
			case (irq_wr.op)
				map90_pkg::IRQ_MODE: mode <= irq_wr.dat;
				map90_pkg::IRQ_ENABLE: irq_on <= 1'b1;
				map90_pkg::IRQ_DISABLE:
				begin
					irq_on <= 1'b0;
					irq <= 1'b0; // Acknowledge
				end
				map90_pkg::IRQ_PRESCALE: prescale <= irq_wr.dat ^ xor_val;
				map90_pkg::IRQ_COUNT: count <= irq_wr.dat ^ xor_val;
				map90_pkg::IRQ_XOR: xor_val <= irq_wr.dat;
				default: ;
			endcase
			if (step)
			begin
				if (short_pre)
					prescale[2:0] <= prescale[2:0] + 3'd1;
				else
					prescale <= prescale + 1'b1;
				irq_inc <= wrap;
				if (irq_inc)
				begin
					case (dir)
						map90_pkg::DIR_DOWN:
						begin
							count <= count - 1'b1;
							if (irq_on && count == 8'h00)
								irq <= 1'b1;
						end
						map90_pkg::DIR_UP:
						begin
							count <= count + 1'b1;
							if (irq_on && count == 8'hff)
								irq <= 1'b1;
						end
						default: ;
					endcase
				end
			end
		end
	end

	ap_irq_enabled: assert property (@(posedge m2) disable iff (map_rst)
		$rose(irq) |-> $past(irq_on))
		else $error("irq rose while disabled");

endmodule

// File: map90_pkg.sv
`include "map90_config.svh"

package map90_pkg;

	typedef struct packed {
		logic                    cyc;
		logic                    stb;
		logic                    we;
		logic [`MAP90_ADR_W-1:0] adr;
		logic [`MAP90_DAT_W-1:0] dat_w;
	} wb_req_t;

	// Complete banking state shared by the PRG and CHR mappers
	typedef struct packed {
		logic [3:0][6:0]  prg_reg;
		logic [7:0][15:0] chr_reg;
		logic [3:0][15:0] nt_reg;
		logic [3:0][7:0]  control;
	} map_regs_t;

	typedef enum logic [2:0] {
		PRG_32K_LAST   = 3'd0,
		PRG_16K        = 3'd1,
		PRG_8K         = 3'd2,
		PRG_8K_REV     = 3'd3,
		PRG_32K_SEL    = 3'd4,
		PRG_16K_SEL    = 3'd5,
		PRG_8K_SEL     = 3'd6,
		PRG_8K_SEL_REV = 3'd7
	} prg_mode_e;

	typedef enum logic [1:0] {CHR_8K, CHR_4K, CHR_2K, CHR_1K} chr_mode_e;

	typedef enum logic [1:0] {MIR_VERT, MIR_HORZ, MIR_ONE_LO, MIR_ONE_HI} mirror_e;

	typedef enum logic [2:0] {
		IRQ_NONE, IRQ_MODE, IRQ_ENABLE, IRQ_DISABLE, IRQ_PRESCALE, IRQ_COUNT, IRQ_XOR
	} irq_op_e;

	typedef enum logic [1:0] {SRC_CPU = 2'd0, SRC_A12 = 2'd1} irq_src_e;

	typedef enum logic [1:0] {DIR_HOLD = 2'd0, DIR_UP = 2'd1, DIR_DOWN = 2'd2} irq_dir_e;

	typedef struct packed {
		irq_op_e                 op;
		logic [`MAP90_DAT_W-1:0] dat;
	} irq_wr_t;

endpackage

// File: map90_prg_map.sv
`timescale 1ns/10ps
`include "map90_config.svh"

module map90_prg_map
(
	input  map90_pkg::map_regs_t    regs,
	input  logic [`MAP90_ADR_W-1:0] cpu_addr,
	input  logic                    rom_sel,
	output logic [`MAP90_PRG_W-1:0] prg_addr,
	output logic                    rom_ce
);

	map90_pkg::prg_mode_e prg_mode;
	logic                 win6;
	logic [1:0]           slot;
	logic [6:0]           bank;
	logic [6:0]           bank_8k;
	logic [6:0]           bank_8k_sel;

	function automatic logic [6:0] rev7(input logic [6:0] b);
		logic [6:0] r;
		for (int i = 0; i < 7; i++)
		begin
			r[i] = b[6 - i];
		end
		return r;
	endfunction

	assign prg_mode = map90_pkg::prg_mode_e'(regs.control[0][2:0]);
	assign slot = cpu_addr[14:13];
	assign win6 = !rom_sel && slot == 2'b11; // 6000-7FFF
	assign rom_ce = rom_sel | (win6 & regs.control[0][7]);

	assign bank_8k = !rom_sel ? regs.prg_reg[3] : (slot == 2'b11 ? 7'h7f : regs.prg_reg[slot]);
	assign bank_8k_sel = !rom_sel ? regs.prg_reg[3] : regs.prg_reg[slot];

	always_comb
	begin
		case (prg_mode)
			map90_pkg::PRG_32K_LAST:
				bank = !rom_sel ? {regs.prg_reg[3][4:0], 2'b11} : {5'h1f, slot};
			map90_pkg::PRG_16K:
				bank = !rom_sel ? {regs.prg_reg[3][5:0], 1'b1} :
					!slot[1] ? {regs.prg_reg[1][5:0], slot[0]} : {6'h3f, slot[0]};
			map90_pkg::PRG_8K: bank = bank_8k;
			map90_pkg::PRG_8K_REV: bank = rev7(bank_8k);
			map90_pkg::PRG_32K_SEL:
				bank = !rom_sel ? {regs.prg_reg[3][4:0], 2'b11} : {regs.prg_reg[3][4:0], slot};
			map90_pkg::PRG_16K_SEL:
				bank = !rom_sel ? {regs.prg_reg[3][5:0], 1'b1} :
					!slot[1] ? {regs.prg_reg[1][5:0], slot[0]} : {regs.prg_reg[3][5:0], slot[0]};
			map90_pkg::PRG_8K_SEL: bank = bank_8k_sel;
			default: bank = rev7(bank_8k_sel);
		endcase
	end

	assign prg_addr = {bank[`MAP90_PRG_W-14:0], cpu_addr[12:0]};

endmodule

// File: map90_regs.sv
`timescale 1ns/10ps
`include "map90_config.svh"

module map90_regs
(
	input  logic                    m2,
	input  logic                    map_rst,
	input  map90_pkg::wb_req_t      wb_req,
	output logic [`MAP90_DAT_W-1:0] wb_dat_r,
	output logic                    wb_ack,
	output map90_pkg::map_regs_t    regs,
	output map90_pkg::irq_wr_t      irq_wr
);

	logic [`MAP90_DAT_W-1:0]   ram [8];
	logic [`MAP90_DAT_W-1:0]   mul_inp [2];
	logic [2*`MAP90_DAT_W-1:0] mul_rez;
	logic                      mul_req;
	logic                      req;
	logic                      wr_go;
	logic                      rd_go;
	logic [`MAP90_ADR_W-1:0]   win;
	logic                      mul_sel;
	logic                      ram_sel;
	map90_pkg::irq_op_e        irq_op;

	assign req = wb_req.cyc & wb_req.stb & !wb_ack; // One transfer per two cycles
	assign wr_go = req & wb_req.we;
	assign rd_go = req & !wb_req.we;
	assign win = {wb_req.adr[`MAP90_ADR_W-1:3], 3'b000};
	assign mul_sel = {wb_req.adr[`MAP90_ADR_W-1:1], 1'b0} == `MAP90_MUL_BASE;
	assign ram_sel = win == `MAP90_RAM_BASE;

	// C000 window sub-address decode
	always_comb
	begin
		case (wb_req.adr[2:0])
			3'd0: irq_op = wb_req.dat_w[0] ? map90_pkg::IRQ_ENABLE : map90_pkg::IRQ_DISABLE;
			3'd1: irq_op = map90_pkg::IRQ_MODE;
			3'd2: irq_op = map90_pkg::IRQ_DISABLE;
			3'd3: irq_op = map90_pkg::IRQ_ENABLE;
			3'd4: irq_op = map90_pkg::IRQ_PRESCALE;
			3'd5: irq_op = map90_pkg::IRQ_COUNT;
			3'd6: irq_op = map90_pkg::IRQ_XOR;
			default: irq_op = map90_pkg::IRQ_NONE;
		endcase
	end

	always_ff @(posedge m2)
	begin
		irq_wr.dat <= wb_req.dat_w;
		if (map_rst)
		begin
			wb_ack <= 1'b0;
			mul_req <= 1'b0;
			irq_wr.op <= map90_pkg::IRQ_NONE;
		end
		else
		begin
			wb_ack <= req;
			mul_req <= wr_go & mul_sel; // Product lands on the next edge
			irq_wr.op <= (wr_go && win == 16'hC000) ? irq_op : map90_pkg::IRQ_NONE;
		end
	end

	always_ff @(posedge m2)
	begin
		if (map_rst)
		begin
			regs.control[0] <= '0;
			regs.control[3] <= '0;
		end
		else if (wr_go)
		begin
			case (win)
				16'h8000: regs.prg_reg[wb_req.adr[1:0]] <= wb_req.dat_w[6:0];
				16'h9000: regs.chr_reg[wb_req.adr[2:0]][7:0] <= wb_req.dat_w;
				16'hA000: regs.chr_reg[wb_req.adr[2:0]][15:8] <= wb_req.dat_w;
				16'hB000:
				begin
					if (wb_req.adr[2])
						regs.nt_reg[wb_req.adr[1:0]][15:8] <= wb_req.dat_w;
					else
						regs.nt_reg[wb_req.adr[1:0]][7:0] <= wb_req.dat_w;
				end
				16'hD000: regs.control[wb_req.adr[1:0]] <= wb_req.dat_w;
				default: ;
			endcase
		end
	end

	always_ff @(posedge m2)
	begin
		if (wr_go && ram_sel)
			ram[wb_req.adr[2:0]] <= wb_req.dat_w;
		if (wr_go && mul_sel)
			mul_inp[wb_req.adr[0]] <= wb_req.dat_w;
		if (mul_req)
			mul_rez <= mul_inp[0] * mul_inp[1];
		if (rd_go)
		begin
			if (mul_sel)
				wb_dat_r <= wb_req.adr[0] ? mul_rez[15:8] : mul_rez[7:0];
			else if (ram_sel)
				wb_dat_r <= ram[wb_req.adr[2:0]];
			else
				wb_dat_r <= '1; // Open bus
		end
	end

	ap_ack_single: assert property (@(posedge m2) disable iff (map_rst) wb_ack |=> !wb_ack)
		else $error("wb_ack high on two consecutive cycles");

endmodule

// File: map90_tb.sv
`timescale 1ns/10ps
`include "map90_config.svh"

module map90_tb;

	localparam int CLK_NS = 4;
	localparam int TEST_STEPS = 5;
	localparam int CYCLES_PER_STEP = 200;

	logic                    m2 = 1'b0;
	logic                    map_rst;
	map90_pkg::wb_req_t      wb_req;
	logic [`MAP90_DAT_W-1:0] wb_dat_r;
	logic                    wb_ack;
	logic [`MAP90_ADR_W-1:0] cpu_addr;
	logic                    rom_sel;
	logic [`MAP90_PRG_W-1:0] prg_addr;
	logic                    rom_ce;
	logic [13:0]             ppu_addr;
	logic                    ppu_a12;
	logic [`MAP90_CHR_W-1:0] chr_addr;
	logic                    ciram_a10;
	logic                    ciram_ce;
	logic                    irq;

	// Check enables, set on the falling edge and sampled on the next rising edge
	logic                    idle_chk;
	logic                    rd_chk;
	logic                    prg_chk;
	logic                    ce_chk;
	logic                    chr_chk;
	logic                    a10_chk;
	logic                    cce_chk;
	logic                    irq_chk;
	logic [`MAP90_DAT_W-1:0] rd_exp;
	logic [`MAP90_PRG_W-1:0] prg_exp;
	logic                    ce_exp;
	logic [`MAP90_CHR_W-1:0] chr_exp;
	logic                    a10_exp;
	logic                    cce_exp;
	logic                    irq_exp;

	logic [6:0]              prg_bank [4];
	logic [15:0]             chr_val [8];
	logic [15:0]             nt_val [4];
	logic [7:0]              ram_val [8];

	map90_top dut_i (
		.m2(m2),
		.map_rst(map_rst),
		.wb_req(wb_req),
		.wb_dat_r(wb_dat_r),
		.wb_ack(wb_ack),
		.cpu_addr(cpu_addr),
		.rom_sel(rom_sel),
		.prg_addr(prg_addr),
		.rom_ce(rom_ce),
		.ppu_addr(ppu_addr),
		.ppu_a12(ppu_a12),
		.chr_addr(chr_addr),
		.ciram_a10(ciram_a10),
		.ciram_ce(ciram_ce),
		.irq(irq)
	);

	always #(CLK_NS / 2) m2 = ~m2;

	task automatic fail_value(input string name, input logic [31:0] exp_v, input logic [31:0] act_v);
		$display("Fail at %0t: %s expected 'h%0h, got 'h%0h", $time, name, exp_v, act_v);
		$display("tests failed");
		$fatal(1, "value mismatch on %s", name);
	endtask

	task automatic fail_text(input string what);
		$display("At %0t: %s", $time, what);
		$display("tests failed");
		$fatal(1, "run stopped");
	endtask

	ap_ack_follows: assert property (@(posedge m2) disable iff (map_rst)
		(wb_req.cyc && wb_req.stb && !wb_ack) |=> wb_ack)
		else fail_text("wb_ack did not follow stb by one cycle");
	ap_ack_idle: assert property (@(posedge m2) disable iff (map_rst) idle_chk |-> !wb_ack)
		else fail_value("wb_ack", 32'd0, 32'($sampled(wb_ack)));
	ap_rd_data: assert property (@(posedge m2) disable iff (map_rst)
		rd_chk |-> wb_dat_r == rd_exp)
		else fail_value("wb_dat_r", 32'(rd_exp), 32'($sampled(wb_dat_r)));
	ap_prg_addr: assert property (@(posedge m2) disable iff (map_rst)
		prg_chk |-> prg_addr == prg_exp)
		else fail_value("prg_addr", 32'(prg_exp), 32'($sampled(prg_addr)));
	ap_rom_ce: assert property (@(posedge m2) disable iff (map_rst) ce_chk |-> rom_ce == ce_exp)
		else fail_value("rom_ce", 32'(ce_exp), 32'($sampled(rom_ce)));
	ap_chr_addr: assert property (@(posedge m2) disable iff (map_rst)
		chr_chk |-> chr_addr == chr_exp)
		else fail_value("chr_addr", 32'(chr_exp), 32'($sampled(chr_addr)));
	ap_ciram_a10: assert property (@(posedge m2) disable iff (map_rst)
		a10_chk |-> ciram_a10 == a10_exp)
		else fail_value("ciram_a10", 32'(a10_exp), 32'($sampled(ciram_a10)));
	ap_ciram_ce: assert property (@(posedge m2) disable iff (map_rst)
		cce_chk |-> ciram_ce == cce_exp)
		else fail_value("ciram_ce", 32'(cce_exp), 32'($sampled(ciram_ce)));
	ap_irq: assert property (@(posedge m2) disable iff (map_rst) irq_chk |-> irq == irq_exp)
		else fail_value("irq", 32'(irq_exp), 32'($sampled(irq)));

	function automatic logic [6:0] reverse_bits7(input logic [6:0] b);
		logic [6:0] r;
		r = {<<{b}};
		return r;
	endfunction

	// One classic cycle, returns on the falling edge where ack is seen
	task automatic wb_transfer(input logic [15:0] adr, input logic we, input logic [7:0] dat);
		int wait_cnt;
		wait_cnt = 0;
		wb_req.cyc = 1'b1;
		wb_req.stb = 1'b1;
		wb_req.we = we;
		wb_req.adr = adr;
		wb_req.dat_w = dat;
		do
		begin
			@(negedge m2);
			wait_cnt++;
		end
		while (!wb_ack && wait_cnt < 8);
		ap_ack_seen: assert (wb_ack) else fail_text("no wb_ack within 8 cycles");
		wb_req = '0;
	endtask

	task automatic wb_write(input logic [15:0] adr, input logic [7:0] dat);
		wb_transfer(adr, 1'b1, dat);
	endtask

	task automatic wb_read(input logic [15:0] adr, input logic [7:0] exp_v);
		wb_transfer(adr, 1'b0, 8'h00);
		rd_exp = exp_v;
		rd_chk = 1'b1;
		@(negedge m2);
		rd_chk = 1'b0;
	endtask

	task automatic probe_prg(input logic [15:0] addr, input logic rsel, input logic [6:0] bank,
		input logic chk_bank, input logic ce_v);
		cpu_addr = addr;
		rom_sel = rsel;
		prg_exp = {bank[5:0], addr[12:0]};
		ce_exp = ce_v;
		prg_chk = chk_bank;
		ce_chk = 1'b1;
		@(negedge m2);
		prg_chk = 1'b0;
		ce_chk = 1'b0;
	endtask

	task automatic probe_chr(input logic [13:0] addr, input logic [8:0] bank,
		input logic chk_bank, input logic a10_v, input logic chk_a10,
		input logic ce_v, input logic chk_ce);
		ppu_addr = addr;
		chr_exp = {bank, addr[9:0]};
		a10_exp = a10_v;
		cce_exp = ce_v;
		chr_chk = chk_bank;
		a10_chk = chk_a10;
		cce_chk = chk_ce;
		@(negedge m2);
		chr_chk = 1'b0;
		a10_chk = 1'b0;
		cce_chk = 1'b0;
	endtask

	task automatic test_reset_bus();
		idle_chk = 1'b1;
		irq_exp = 1'b0;
		irq_chk = 1'b1;
		@(negedge m2);
		idle_chk = 1'b0;
		irq_chk = 1'b0;
		for (int i = 2; i < 8; i++)
		begin
			ram_val[i] = 8'($urandom);
			wb_write(`MAP90_RAM_BASE + 16'(i), ram_val[i]);
		end
		for (int i = 2; i < 8; i++)
		begin
			wb_read(`MAP90_RAM_BASE + 16'(i), ram_val[i]);
		end
	endtask

	task automatic test_multiplier();
		logic [7:0]  a;
		logic [7:0]  b;
		logic [15:0] prod;
		a = 8'($urandom);
		b = 8'($urandom);
		prod = 16'(a) * 16'(b);
		wb_write(`MAP90_MUL_BASE, a);
		wb_write(`MAP90_MUL_BASE + 16'd1, b);
		repeat (2) @(negedge m2); // Product needs one extra edge
		wb_read(`MAP90_MUL_BASE, prod[7:0]);
		wb_read(`MAP90_MUL_BASE + 16'd1, prod[15:8]);
	endtask

	task automatic test_prg();
		logic [15:0] base;
		for (int i = 0; i < 4; i++)
		begin
			prg_bank[i] = 7'($urandom);
			wb_write(16'h8000 + 16'(i), {1'b0, prg_bank[i]});
		end
		wb_write(16'hD000, 8'h02); // PRG_8K, 6000 window off
		for (int w = 0; w < 3; w++)
		begin
			base = 16'h8000 + 16'(w * 16'h2000);
			probe_prg(base | 16'($urandom & 32'h1fff), 1'b1, prg_bank[w], 1'b1, 1'b1);
		end
		probe_prg(16'hE000 | 16'($urandom & 32'h1fff), 1'b1, 7'h7f, 1'b1, 1'b1);
		probe_prg(16'h6000 | 16'($urandom & 32'h1fff), 1'b0, 7'h00, 1'b0, 1'b0);
		wb_write(16'hD000, 8'h83); // PRG_8K_REV with ROM at 6000
		for (int w = 0; w < 3; w++)
		begin
			base = 16'h8000 + 16'(w * 16'h2000);
			probe_prg(base | 16'($urandom & 32'h1fff), 1'b1, reverse_bits7(prg_bank[w]),
				1'b1, 1'b1);
		end
		probe_prg(16'hE000 | 16'($urandom & 32'h1fff), 1'b1, 7'h7f, 1'b1, 1'b1);
		probe_prg(16'h6000 | 16'($urandom & 32'h1fff), 1'b0, reverse_bits7(prg_bank[3]),
			1'b1, 1'b1);
		probe_prg(16'h4020, 1'b0, 7'h00, 1'b0, 1'b0);
	endtask

	task automatic test_chr();
		logic [13:0] addr;
		logic        a10_v;
		for (int s = 0; s < 8; s++)
		begin
			chr_val[s] = 16'($urandom);
			wb_write(16'h9000 + 16'(s), chr_val[s][7:0]);
			wb_write(16'hA000 + 16'(s), chr_val[s][15:8]);
		end
		wb_write(16'hD000, 8'h1A); // CHR_1K
		wb_write(16'hD003, 8'h00);
		for (int s = 0; s < 8; s++)
		begin
			addr = {1'b0, 3'(s), 10'($urandom)};
			probe_chr(addr, chr_val[s][8:0], 1'b1, 1'b0, 1'b0, 1'b1, 1'b1); // CIRAM stays off
		end
		for (int m = 0; m < 4; m++)
		begin
			wb_write(16'hD001, 8'(m));
			for (int t = 0; t < 4; t++)
			begin
				addr = {2'b10, 2'(t), 10'($urandom)};
				case (m)
					0: a10_v = addr[10];
					1: a10_v = addr[11];
					2: a10_v = 1'b0;
					default: a10_v = 1'b1;
				endcase
				probe_chr(addr, 9'h000, 1'b0, a10_v, 1'b1, 1'b0, 1'b1);
			end
		end
		for (int t = 0; t < 4; t++)
		begin
			nt_val[t] = 16'($urandom);
			wb_write(16'hB000 + 16'(t), nt_val[t][7:0]);
			wb_write(16'hB004 + 16'(t), nt_val[t][15:8]);
		end
		wb_write(16'hD000, 8'h3A); // Nametables from ROM
		for (int t = 0; t < 4; t++)
		begin
			addr = {2'b10, 2'(t), 10'($urandom)};
			probe_chr(addr, nt_val[t][8:0], 1'b1, 1'b0, 1'b0, 1'b0, 1'b0);
		end
	endtask

	task automatic test_irq();
		int n;
		int k;
		int limit;
		n = 1 + int'($urandom % 12);
		limit = 8 * (n + 1) + 3;
		wb_write(16'hC001, 8'h84); // CPU cycles, 3-bit prescaler, count down
		wb_write(16'hC004, 8'h00);
		wb_write(16'hC005, 8'(n));
		wb_write(16'hC003, 8'h00);
		k = 0;
		while (!irq && k <= limit)
		begin
			@(negedge m2);
			k++;
		end
		ap_irq_late: assert (irq) else fail_text("irq did not rise before its deadline");
		ap_irq_early: assert (k >= 8 * n) else fail_value("irq rise cycle", 32'(8 * n), 32'(k));
		wb_write(16'hC002, 8'h00);
		@(negedge m2);
		irq_exp = 1'b0;
		irq_chk = 1'b1;
		@(negedge m2);
		irq_chk = 1'b0;
	endtask

	initial
	begin
		#(TEST_STEPS * CYCLES_PER_STEP * CLK_NS);
		fail_text("watchdog expired before the tests finished");
	end

	initial
	begin
		void'($urandom(32'h3fe4345d));
		map_rst = 1'b1;
		wb_req = '0;
		cpu_addr = '0;
		rom_sel = 1'b0;
		ppu_addr = '0;
		ppu_a12 = 1'b0;
		idle_chk = 1'b0;
		rd_chk = 1'b0;
		prg_chk = 1'b0;
		ce_chk = 1'b0;
		chr_chk = 1'b0;
		a10_chk = 1'b0;
		cce_chk = 1'b0;
		irq_chk = 1'b0;
		rd_exp = '0;
		prg_exp = '0;
		ce_exp = 1'b0;
		chr_exp = '0;
		a10_exp = 1'b0;
		cce_exp = 1'b0;
		irq_exp = 1'b0;
		repeat (4) @(posedge m2);
		@(negedge m2);
		map_rst = 1'b0;
		test_reset_bus();
		test_multiplier();
		test_prg();
		test_chr();
		test_irq();
		$display("all tests passed");
		$finish;
	end

endmodule

// File: map90_top.sv
`timescale 1ns/10ps
`include "map90_config.svh"

module map90_top
(
	input  logic                    m2,
	input  logic                    map_rst,
	input  map90_pkg::wb_req_t      wb_req,
	output logic [`MAP90_DAT_W-1:0] wb_dat_r,
	output logic                    wb_ack,
	input  logic [`MAP90_ADR_W-1:0] cpu_addr,
	input  logic                    rom_sel,
	output logic [`MAP90_PRG_W-1:0] prg_addr,
	output logic                    rom_ce,
	input  logic [13:0]             ppu_addr,
	input  logic                    ppu_a12,
	output logic [`MAP90_CHR_W-1:0] chr_addr,
	output logic                    ciram_a10,
	output logic                    ciram_ce,
	output logic                    irq
);

	map90_pkg::map_regs_t regs;
	map90_pkg::irq_wr_t   irq_wr;

	map90_regs map90_regs_i (
		.m2(m2),
		.map_rst(map_rst),
		.wb_req(wb_req),
		.wb_dat_r(wb_dat_r),
		.wb_ack(wb_ack),
		.regs(regs),
		.irq_wr(irq_wr)
	);

	map90_irq map90_irq_i (
		.m2(m2),
		.map_rst(map_rst),
		.irq_wr(irq_wr),
		.ppu_a12(ppu_a12),
		.irq(irq)
	);

	map90_prg_map map90_prg_map_i (
		.regs(regs),
		.cpu_addr(cpu_addr),
		.rom_sel(rom_sel),
		.prg_addr(prg_addr),
		.rom_ce(rom_ce)
	);

	map90_chr_map map90_chr_map_i (
		.regs(regs),
		.ppu_addr(ppu_addr),
		.chr_addr(chr_addr),
		.ciram_a10(ciram_a10),
		.ciram_ce(ciram_ce)
	);

endmodule
